/* dmm_settings.svh */
// register map, chip-select codes and mode codes for the dmm controller
// addresses are 7 bit to fit the spi frame address field
`ifndef DMM_SETTINGS_SVH
`define DMM_SETTINGS_SVH

// register addresses
`define DMM_REG_CR              7'd1
`define DMM_REG_DIRECT          7'd2
`define DMM_REG_STATUS          7'd3    // read only
`define DMM_REG_4094_OE         7'd4
`define DMM_REG_SA_PRECHARGE    7'd5
`define DMM_REG_SA_SEQ_N        7'd6
`define DMM_REG_SA_SEQ0         7'd7
`define DMM_REG_SA_SEQ1         7'd8
`define DMM_REG_SA_SEQ2         7'd9
`define DMM_REG_SA_SEQ3         7'd10
`define DMM_REG_ADC_APERTURE    7'd11

// spi_cs_vec_i codes
`define DMM_CS_DEASSERT         3'd0
`define DMM_CS_FPGA0            3'd1
`define DMM_CS_4094             3'd2
`define DMM_CS_INVERT_DAC       3'd3
`define DMM_CS_MDAC1            3'd4

// cr mode field
`define DMM_MODE_DIRECT         3'd0
`define DMM_MODE_SEQ_MOCK       3'd6

`define DMM_STATUS_MAGIC        8'hAA
`define DMM_REG_W               32
`define DMM_SEQ_MAX             4       // sequence entries
`define DMM_CNT_W               24      // precharge counter

`endif

/* dmm_reg_pkg.sv */
// register-map types, the pin word and the status word
// pin_fields_t and status_fields_t must stay exactly one register wide
`default_nettype none
`include "dmm_settings.svh"

package dmm_reg_pkg;

  typedef logic [`DMM_REG_W-1:0] reg_word_t;

  // one word of pin drive, msb first here, lsb is leds
  typedef struct packed {
    logic [7:0] unused;
    logic       spi_interrupt;     // 23
    logic       adc_cmpr_latch;    // 22
    logic       adc_sigmux;        // 21
    logic       adc_rstmux;        // 20
    logic [1:0] adc_refmux;        // 19:18
    logic [3:0] azmux;             // 17:14
    logic [1:0] pc_sw;             // 13:12
    logic [7:0] monitor;           // 11:4
    logic [3:0] leds;              // 3:0
  } pin_fields_t;

  // direct register word seen as pin fields
  typedef union packed {
    reg_word_t   word;
    pin_fields_t f;
  } pin_word_u;

  typedef struct packed {
    logic [`DMM_REG_W-4:0] rsvd;
    logic [2:0]            mode;
  } cr_fields_t;

  typedef struct packed {
    logic [8:0] zero_hi;
    logic [2:0] seq_n;             // 22:20
    logic       first;             // 19
    logic [2:0] sample_idx;        // 18:16
    logic [3:0] zero_lo;
    logic [3:0] hw_flags;          // 11:8
    logic [7:0] magic;             // 7:0
  } status_fields_t;

endpackage

`default_nettype wire

/* dmm_acq_pkg.sv */
// acquisition types shared by the register set, sequencer and adc mock
// seq_n above the entry count is clamped by the sequencer
`default_nettype none
`include "dmm_settings.svh"

package dmm_acq_pkg;

  // one programmed step, low bits azmux
  typedef struct packed {
    logic [1:0] pc_sw;
    logic [3:0] azmux;
  } seq_entry_t;

  typedef struct packed {
    logic [2:0]                    seq_n;
    seq_entry_t [`DMM_SEQ_MAX-1:0] seq;
    logic [`DMM_CNT_W-1:0]         precharge;   // clk cycles adc held in reset
    dmm_reg_pkg::reg_word_t        aperture;    // clk cycles per sample
  } acq_params_t;

  // sequencer drive toward the mode mux
  typedef struct packed {
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic [3:0] leds;
    logic [7:0] monitor;
  } seq_pins_t;

endpackage

`default_nettype wire

/* spi_register_set.sv */
// spi mode 0 register set, 40 bit frames: write flag, 7 bit addr, 32 data
// lines are sampled in the CLK domain, so SCK must run slower than CLK/8
// writes commit at select end, only after exactly 40 bits
`timescale 1ns/1ns
`default_nettype none
`include "dmm_settings.svh"

module spi_register_set (
  input  wire logic                   CLK,
  input  wire logic                   rst_n_i,
  input  wire logic                   sck_i,
  input  wire logic                   sdi_i,
  input  wire logic                   sel_i,      // active high
  input  wire dmm_reg_pkg::reg_word_t status_i,
  output logic                        sdo_o,
  output dmm_reg_pkg::cr_fields_t     cr_o,
  output dmm_reg_pkg::reg_word_t      direct_o,
  output logic                        oe_4094_o,
  output dmm_acq_pkg::acq_params_t    params_o
);

  localparam int FRAME_BITS = 40;

  logic [3:0] sck_r;                  // [2] is the synced level, [3] for edges
  logic [2:0] sdi_r;
  logic [3:0] sel_r;
  logic       sel, sck_rise, sck_fall, sel_fall;

  logic [5:0] bit_cnt;
  logic       overrun;                // more than 40 clocks seen
  logic       addr_done;              // address bits complete, load read data
  logic       wr_en;

  logic [FRAME_BITS-1:0]  in_sr;
  dmm_reg_pkg::reg_word_t rd_sr, rd_data;

  dmm_reg_pkg::cr_fields_t cr_q;
  dmm_reg_pkg::reg_word_t  direct_q, oe_q, prech_q, seq_n_q, aper_q;
  dmm_reg_pkg::reg_word_t  seq_q [`DMM_SEQ_MAX];

  //////////////////////////////////////////////////
  // synchroniser and edges

  always_ff @(posedge CLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sck_r <= '0;
      sdi_r <= '0;
      sel_r <= '0;
    end
    else
    begin
      sck_r <= {sck_r[2:0], sck_i};
      sdi_r <= {sdi_r[1:0], sdi_i};
      sel_r <= {sel_r[2:0], sel_i};
    end
  end

  assign sel      = sel_r[2];
  assign sck_rise = sck_r[2] & ~sck_r[3];
  assign sck_fall = ~sck_r[2] & sck_r[3];
  assign sel_fall = ~sel_r[2] & sel_r[3];

  //////////////////////////////////////////////////
  // frame shift and bit count

  always_ff @(posedge CLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      bit_cnt   <= '0;
      overrun   <= 1'b0;
      addr_done <= 1'b0;
    end
    else if (!sel)
    begin
      bit_cnt   <= '0;              // sel_fall cycle still sees the old count
      overrun   <= 1'b0;
      addr_done <= 1'b0;
    end
    else
    begin
      addr_done <= sck_rise && (bit_cnt == 6'd7);
      if (sck_rise)
      begin
        if (bit_cnt == FRAME_BITS)
          overrun <= 1'b1;          // saturate, frame gets dropped
        else
          bit_cnt <= bit_cnt + 6'd1;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (sel && sck_rise)
      in_sr <= {in_sr[FRAME_BITS-2:0], sdi_r[2]};   // msb first
    if (addr_done)
      rd_sr <= rd_data;
    else if (sel && sck_fall && bit_cnt >= 6'd8)
      rd_sr <= {rd_sr[`DMM_REG_W-2:0], 1'b0};
  end

  // sdo moves on falling sck, host samples on the next rise
  always_ff @(posedge CLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
      sdo_o <= 1'b0;
    else if (!sel)
      sdo_o <= 1'b0;
    else if (sck_fall && bit_cnt >= 6'd8)
      sdo_o <= rd_sr[`DMM_REG_W-1];
  end

  // address sits in the low bits once 8 bits are in
  always_comb
  begin
    case (in_sr[6:0])
      `DMM_REG_CR:           rd_data = cr_q;
      `DMM_REG_DIRECT:       rd_data = direct_q;
      `DMM_REG_STATUS:       rd_data = status_i;
      `DMM_REG_4094_OE:      rd_data = oe_q;
      `DMM_REG_SA_PRECHARGE: rd_data = prech_q;
      `DMM_REG_SA_SEQ_N:     rd_data = seq_n_q;
      `DMM_REG_SA_SEQ0:      rd_data = seq_q[0];
      `DMM_REG_SA_SEQ1:      rd_data = seq_q[1];
      `DMM_REG_SA_SEQ2:      rd_data = seq_q[2];
      `DMM_REG_SA_SEQ3:      rd_data = seq_q[3];
      `DMM_REG_ADC_APERTURE: rd_data = aper_q;
      default:               rd_data = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // write commit

  assign wr_en = sel_fall && (bit_cnt == FRAME_BITS) && !overrun && in_sr[FRAME_BITS-1];

  always_ff @(posedge CLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cr_q     <= '0;
      direct_q <= '0;
      oe_q     <= '0;
      prech_q  <= '0;
      seq_n_q  <= '0;
      aper_q   <= '0;
      seq_q    <= '{default: '0};
    end
    else if (wr_en)
    begin
      case (in_sr[38:32])
        `DMM_REG_CR:           cr_q     <= in_sr[31:0];
        `DMM_REG_DIRECT:       direct_q <= in_sr[31:0];
        `DMM_REG_4094_OE:      oe_q     <= in_sr[31:0];
        `DMM_REG_SA_PRECHARGE: prech_q  <= in_sr[31:0];
        `DMM_REG_SA_SEQ_N:     seq_n_q  <= in_sr[31:0];
        `DMM_REG_SA_SEQ0:      seq_q[0] <= in_sr[31:0];
        `DMM_REG_SA_SEQ1:      seq_q[1] <= in_sr[31:0];
        `DMM_REG_SA_SEQ2:      seq_q[2] <= in_sr[31:0];
        `DMM_REG_SA_SEQ3:      seq_q[3] <= in_sr[31:0];
        `DMM_REG_ADC_APERTURE: aper_q   <= in_sr[31:0];
        default: ;                  // status and unknown, dropped
      endcase
    end
  end

  assign cr_o      = cr_q;
  assign direct_o  = direct_q;
  assign oe_4094_o = oe_q[0];

  always_comb
  begin
    params_o.seq_n = seq_n_q[2:0];
    for (int i = 0; i < `DMM_SEQ_MAX; i++)
      params_o.seq[i] = seq_q[i][5:0];    // pc_sw, azmux
    params_o.precharge = prech_q[`DMM_CNT_W-1:0];
    params_o.aperture  = aper_q;
  end

  a_bit_cnt_max: assert property (@(posedge CLK) disable iff (!rst_n_i)
    sel |-> bit_cnt <= FRAME_BITS);

endmodule

`default_nettype wire

/* adc_mock.sv */
// stand-in for the adc, one measure-valid strobe per reset release
// an aperture of 0 behaves as 1
`timescale 1ns/1ns
`default_nettype none

module adc_mock (
  input  wire logic                   CLK,
  input  wire logic                   rst_n_i,
  input  wire logic                   adc_reset_n_i,
  input  wire dmm_reg_pkg::reg_word_t aperture_i,
  output logic                        measure_valid_o
);

  dmm_reg_pkg::reg_word_t cnt_q;
  logic                   done_q;     // strobe given, wait for next reset

  always_ff @(posedge CLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q           <= '0;
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end
    else if (!adc_reset_n_i)
    begin
      cnt_q           <= '0;
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end
    else
    begin
      measure_valid_o <= 1'b0;
      if (!done_q)
      begin
        cnt_q <= cnt_q + 32'd1;
        if (cnt_q + 32'd1 >= aperture_i)
        begin
          measure_valid_o <= 1'b1;  // aperture-th cycle after release
          done_q          <= 1'b1;
        end
      end
    end
  end

  a_single_strobe: assert property (@(posedge CLK) disable iff (!rst_n_i)
    measure_valid_o |=> !measure_valid_o);

endmodule

`default_nettype wire

/* sequence_acquisition.sv */
// steps azmux and pc_sw through the programmed entries while trig_i is high
// each sample: precharge with adc in reset, release, wait for measure valid
// seq_n 0 acts as 1, values above the entry count are clamped
`timescale 1ns/1ns
`default_nettype none
`include "dmm_settings.svh"

module sequence_acquisition (
  input  wire logic                     CLK,
  input  wire logic                     rst_n_i,
  input  wire logic                     trig_i,
  input  wire logic                     measure_valid_i,
  input  wire dmm_acq_pkg::acq_params_t params_i,
  output dmm_acq_pkg::seq_pins_t        pins_o,
  output logic                          adc_reset_n_o,
  output logic [2:0]                    sample_idx_o,   // last completed sample
  output logic                          first_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_PRECHARGE, ST_MEASURE} state_t;

  state_t                  state_q;
  logic [`DMM_CNT_W-1:0]   pc_cnt_q;
  logic [2:0]              idx_q, last_idx;
  logic                    first_pend_q;   // next sample is the first after trig
  dmm_acq_pkg::seq_entry_t cur;
  logic                    busy;

  always_comb
  begin
    if (params_i.seq_n == 3'd0)
      last_idx = 3'd0;
    else if (params_i.seq_n > `DMM_SEQ_MAX)
      last_idx = 3'(`DMM_SEQ_MAX - 1);
    else
      last_idx = params_i.seq_n - 3'd1;
  end

  //////////////////////////////////////////////////
  // fsm

  always_ff @(posedge CLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q       <= ST_IDLE;
      pc_cnt_q      <= '0;
      idx_q         <= '0;
      first_pend_q  <= 1'b0;
      adc_reset_n_o <= 1'b0;
      sample_idx_o  <= '0;
      first_o       <= 1'b0;
    end
    else if (!trig_i)
    begin
      state_q       <= ST_IDLE;     // abort, snapshot kept
      adc_reset_n_o <= 1'b0;
      idx_q         <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          state_q      <= ST_PRECHARGE;
          pc_cnt_q     <= params_i.precharge;
          first_pend_q <= 1'b1;
        end
        ST_PRECHARGE:
        begin
          if (pc_cnt_q <= `DMM_CNT_W'(1))
          begin
            state_q       <= ST_MEASURE;
            adc_reset_n_o <= 1'b1;  // release adc
          end
          else
            pc_cnt_q <= pc_cnt_q - `DMM_CNT_W'(1);
        end
        ST_MEASURE:
        begin
          if (measure_valid_i)
          begin
            sample_idx_o  <= idx_q;
            first_o       <= first_pend_q;
            first_pend_q  <= 1'b0;
            adc_reset_n_o <= 1'b0;
            idx_q         <= (idx_q == last_idx) ? 3'd0 : idx_q + 3'd1;
            pc_cnt_q      <= params_i.precharge;
            state_q       <= ST_PRECHARGE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // pin drive

  assign busy = (state_q != ST_IDLE);
  assign cur  = params_i.seq[idx_q[$clog2(`DMM_SEQ_MAX)-1:0]];

  always_comb
  begin
    pins_o.azmux   = busy ? cur.azmux : 4'd0;
    pins_o.pc_sw   = busy ? cur.pc_sw : 2'd0;
    pins_o.leds    = {1'b0, idx_q};                     // current entry
    pins_o.monitor = {state_q, pins_o.azmux, measure_valid_i, adc_reset_n_o};
  end

  a_reset_in_precharge: assert property (@(posedge CLK) disable iff (!rst_n_i)
    (state_q == ST_PRECHARGE) |-> !adc_reset_n_o);

endmodule

`default_nettype wire

/* output_mode_mux.sv */
// picks the pin word by cr mode, direct register or mock sequencer
// modes other than direct and mode 6 drive every pin low
`timescale 1ns/1ns
`default_nettype none
`include "dmm_settings.svh"

module output_mode_mux (
  input  wire logic [2:0]             mode_i,
  input  wire dmm_reg_pkg::reg_word_t direct_i,
  input  wire dmm_acq_pkg::seq_pins_t seq_i,
  input  wire logic                   adc_reset_n_i,
  output dmm_reg_pkg::pin_word_u      pins_o
);

  always_comb
  begin
    pins_o.word = '0;
    case (mode_i)
      `DMM_MODE_DIRECT:
        pins_o.word = direct_i;     // register decoded as pin fields
      `DMM_MODE_SEQ_MOCK:
      begin
        // adc muxes, latch and interrupt stay low
        pins_o.f.leds    = {adc_reset_n_i, seq_i.leds[2:0]};  // top led lit while integrating
        pins_o.f.monitor = seq_i.monitor;
        pins_o.f.pc_sw   = seq_i.pc_sw;
        pins_o.f.azmux   = seq_i.azmux;
      end
      default:
        pins_o.word = '0;
    endcase
  end

endmodule

`default_nettype wire

/* dmm_top.sv */
// dmm front end controller top, chip-select decode and spi routing
// adc_cmpr_i is unused while the adc is mocked
// spi_iso_cs2 is tied inactive
`timescale 1ns/1ns
`default_nettype none
`include "dmm_settings.svh"

module dmm_top (
  input  wire logic       CLK,
  input  wire logic       rst_n_i,
  input  wire logic       SCK,
  input  wire logic       SDI,
  input  wire logic [2:0] spi_cs_vec_i,
  input  wire logic [3:0] hw_flags_i,
  input  wire logic       spi_glb_miso,
  input  wire logic       adc_cmpr_i,     // unused, no real adc
  input  wire logic       sa_trig_i,
  output logic            SDO,
  output logic [3:0]      leds_o,
  output logic [7:0]      monitor_o,
  output logic            spi_glb_mosi,
  output logic            spi_glb_clk,
  output logic            spi_4094_strobe,
  output logic            spi_4094_oe,
  output logic            spi_iso_cs,
  output logic            spi_iso_cs2,
  output logic            spi_invert_dac_data,
  output logic            spi_invert_dac_clk,
  output logic            spi_invert_dac_ss,
  output logic [1:0]      pc_sw_o,
  output logic [3:0]      azmux_o,
  output logic [1:0]      adc_refmux_o,
  output logic            adc_sigmux_o,
  output logic            adc_rstmux_o,
  output logic            adc_cmpr_latch_ctl_o,
  output logic            spi_interrupt_ctl_o
);

  logic                         fpga_sel, ext_sel, reg_sdo;
  logic [1:0]                   trig_r;           // sa_trig_i synchroniser
  logic                         adc_reset_n, measure_valid, first;
  logic [2:0]                   sample_idx;
  dmm_reg_pkg::cr_fields_t      cr;
  dmm_reg_pkg::reg_word_t       direct;
  dmm_reg_pkg::status_fields_t  status;
  dmm_reg_pkg::pin_word_u       pins;
  dmm_acq_pkg::acq_params_t     params;
  dmm_acq_pkg::seq_pins_t       seq_pins;

  //////////////////////////////////////////////////
  // chip-select decode

  assign fpga_sel = (spi_cs_vec_i == `DMM_CS_FPGA0);
  assign ext_sel  = (spi_cs_vec_i == `DMM_CS_4094) || (spi_cs_vec_i == `DMM_CS_INVERT_DAC) ||
                    (spi_cs_vec_i == `DMM_CS_MDAC1);

  assign spi_glb_clk         = fpga_sel ? 1'b1 : SCK;     // park hi
  assign spi_glb_mosi        = fpga_sel ? 1'b1 : SDI;     // park hi
  assign spi_invert_dac_data = spi_glb_mosi;
  assign spi_invert_dac_clk  = spi_glb_clk;
  assign spi_4094_strobe     = (spi_cs_vec_i == `DMM_CS_4094);         // active hi
  assign spi_invert_dac_ss   = (spi_cs_vec_i != `DMM_CS_INVERT_DAC);   // active lo
  assign spi_iso_cs          = (spi_cs_vec_i != `DMM_CS_MDAC1);        // active lo
  assign spi_iso_cs2         = 1'b1;

  assign SDO = ext_sel ? spi_glb_miso : reg_sdo;  // miso from the selected device

  always_ff @(posedge CLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
      trig_r <= '0;
    else
      trig_r <= {trig_r[0], sa_trig_i};
  end

  always_comb
  begin
    status            = '0;
    status.magic      = `DMM_STATUS_MAGIC;
    status.hw_flags   = hw_flags_i;
    status.sample_idx = sample_idx;
    status.first      = first;
    status.seq_n      = params.seq_n;
  end

  //////////////////////////////////////////////////
  // instances

  spi_register_set i_regs (
    .CLK       (CLK),
    .rst_n_i   (rst_n_i),
    .sck_i     (SCK),
    .sdi_i     (SDI),
    .sel_i     (fpga_sel),
    .status_i  (dmm_reg_pkg::reg_word_t'(status)),
    .sdo_o     (reg_sdo),
    .cr_o      (cr),
    .direct_o  (direct),
    .oe_4094_o (spi_4094_oe),
    .params_o  (params)
  );

  adc_mock i_adc_mock (
    .CLK             (CLK),
    .rst_n_i         (rst_n_i),
    .adc_reset_n_i   (adc_reset_n),
    .aperture_i      (params.aperture),
    .measure_valid_o (measure_valid)
  );

  sequence_acquisition i_seq (
    .CLK             (CLK),
    .rst_n_i         (rst_n_i),
    .trig_i          (trig_r[1]),
    .measure_valid_i (measure_valid),
    .params_i        (params),
    .pins_o          (seq_pins),
    .adc_reset_n_o   (adc_reset_n),
    .sample_idx_o    (sample_idx),
    .first_o         (first)
  );

  output_mode_mux i_mux (
    .mode_i        (cr.mode),
    .direct_i      (direct),
    .seq_i         (seq_pins),
    .adc_reset_n_i (adc_reset_n),
    .pins_o        (pins)
  );

  assign leds_o               = pins.f.leds;
  assign monitor_o            = pins.f.monitor;
  assign pc_sw_o              = pins.f.pc_sw;
  assign azmux_o              = pins.f.azmux;
  assign adc_refmux_o         = pins.f.adc_refmux;
  assign adc_rstmux_o         = pins.f.adc_rstmux;
  assign adc_sigmux_o         = pins.f.adc_sigmux;
  assign adc_cmpr_latch_ctl_o = pins.f.adc_cmpr_latch;
  assign spi_interrupt_ctl_o  = pins.f.spi_interrupt;

endmodule

`default_nettype wire

/* tb_dmm_top.sv */
// testbench for dmm_top, spi host bit-banged at CLK/16, inputs driven on falling CLK
// concurrent assertions hold the checks, stimulus only steers into them
// stimulus words from a galois lfsr, seed fixed
`timescale 1ns/1ns
`default_nettype none
`include "dmm_settings.svh"

module tb_dmm_top;

  localparam int HALF_SCK = 8;        // CLK cycles per sck half period
  localparam int N_SAMPLES = 5;       // samples before trig drops

  logic CLK = 1'b0;
  logic rst_n_i, SCK, SDI, spi_glb_miso, adc_cmpr_i, sa_trig_i;
  logic [2:0] spi_cs_vec_i;
  logic [3:0] hw_flags_i;
  logic SDO, spi_glb_mosi, spi_glb_clk, spi_4094_strobe, spi_4094_oe;
  logic spi_iso_cs, spi_iso_cs2, spi_invert_dac_data, spi_invert_dac_clk, spi_invert_dac_ss;
  logic [3:0] leds_o, azmux_o;
  logic [7:0] monitor_o;
  logic [1:0] pc_sw_o, adc_refmux_o;
  logic adc_sigmux_o, adc_rstmux_o, adc_cmpr_latch_ctl_o, spi_interrupt_ctl_o;

  int errors = 0;
  int timeouts = 0;
  int frames = 0;
  logic [31:0] lfsr = 32'h94f7_2cd2;

  // expected values and check enables
  logic                    chk_pins, chk_oe, seq_chk, rd_chk;
  dmm_reg_pkg::pin_word_u  exp_pins;
  logic                    exp_oe;
  logic [31:0]             rd_got, rd_exp;
  string                   rd_name;
  dmm_acq_pkg::seq_entry_t exp_seq [3];
  logic [1:0]              exp_idx;
  logic [2:0]              seq_n_cfg;
  int                      prech_cycles, low_cnt, sample_cnt;
  logic [1:0]              exp_glb;
  logic [2:0]              exp_dac, exp_cs;

  dmm_top i_dut (.*);

  always #10 CLK = ~CLK;              // 20 ns

  //////////////////////////////////////////////////
  // reference decode of the chip-select vector

  always_comb
  begin
    exp_glb = (spi_cs_vec_i == `DMM_CS_FPGA0) ? 2'b11 : {SCK, SDI};   // clk, mosi
    exp_dac = {exp_glb[0], exp_glb[1], spi_cs_vec_i != `DMM_CS_INVERT_DAC};
    exp_cs  = {spi_cs_vec_i == `DMM_CS_4094, spi_cs_vec_i != `DMM_CS_MDAC1, 1'b1};
  end

  // sequence tracking from what monitor shows
  always @(posedge CLK)
  begin
    if (monitor_o[0])
      low_cnt <= 0;
    else if (low_cnt < 32'h7fff_ffff)
      low_cnt <= low_cnt + 1;         // adc_reset_n low cycles
    if (!seq_chk)
      exp_idx <= 2'd0;
    else if (monitor_o[1])
    begin
      exp_idx    <= (exp_idx == 2'(seq_n_cfg - 3'd1)) ? 2'd0 : exp_idx + 2'd1;
      sample_cnt <= sample_cnt + 1;
    end
  end

  //////////////////////////////////////////////////
  // checks

  a_glb: assert property (@(posedge CLK) disable iff (!rst_n_i)
    {spi_glb_clk, spi_glb_mosi} == exp_glb)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: {spi_glb_clk,spi_glb_mosi} got %b expected %b",
               $time, $sampled({spi_glb_clk, spi_glb_mosi}), $sampled(exp_glb));
    end
  a_dac: assert property (@(posedge CLK) disable iff (!rst_n_i)
    {spi_invert_dac_data, spi_invert_dac_clk, spi_invert_dac_ss} == exp_dac)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: spi_invert_dac lines got %b expected %b",
               $time, $sampled({spi_invert_dac_data, spi_invert_dac_clk, spi_invert_dac_ss}),
               $sampled(exp_dac));
    end
  a_cs: assert property (@(posedge CLK) disable iff (!rst_n_i)
    {spi_4094_strobe, spi_iso_cs, spi_iso_cs2} == exp_cs)
    else
    begin
      errors++;
      $display({"mismatch at %0t ns: {spi_4094_strobe,spi_iso_cs,spi_iso_cs2}",
                " got %b expected %b"},
               $time, $sampled({spi_4094_strobe, spi_iso_cs, spi_iso_cs2}), $sampled(exp_cs));
    end
  a_oe: assert property (@(posedge CLK) disable iff (!rst_n_i) chk_oe |-> spi_4094_oe == exp_oe)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: spi_4094_oe got %b expected %b",
               $time, $sampled(spi_4094_oe), $sampled(exp_oe));
    end

  a_leds: assert property (@(posedge CLK) disable iff (!rst_n_i)
    chk_pins |-> leds_o == exp_pins.f.leds)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: leds_o got %h expected %h",
               $time, $sampled(leds_o), $sampled(exp_pins.f.leds));
    end
  a_monitor: assert property (@(posedge CLK) disable iff (!rst_n_i)
    chk_pins |-> monitor_o == exp_pins.f.monitor)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: monitor_o got %h expected %h",
               $time, $sampled(monitor_o), $sampled(exp_pins.f.monitor));
    end
  a_pc_sw: assert property (@(posedge CLK) disable iff (!rst_n_i)
    chk_pins |-> pc_sw_o == exp_pins.f.pc_sw)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: pc_sw_o got %h expected %h",
               $time, $sampled(pc_sw_o), $sampled(exp_pins.f.pc_sw));
    end
  a_azmux: assert property (@(posedge CLK) disable iff (!rst_n_i)
    chk_pins |-> azmux_o == exp_pins.f.azmux)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: azmux_o got %h expected %h",
               $time, $sampled(azmux_o), $sampled(exp_pins.f.azmux));
    end
  a_adc_ctl: assert property (@(posedge CLK) disable iff (!rst_n_i) chk_pins |->
    {adc_refmux_o, adc_rstmux_o, adc_sigmux_o, adc_cmpr_latch_ctl_o, spi_interrupt_ctl_o} ==
    {exp_pins.f.adc_refmux, exp_pins.f.adc_rstmux, exp_pins.f.adc_sigmux,
     exp_pins.f.adc_cmpr_latch, exp_pins.f.spi_interrupt})
    else
    begin
      errors++;
      $display("mismatch at %0t ns: adc control pins got %b expected %b",
               $time, $sampled({adc_refmux_o, adc_rstmux_o, adc_sigmux_o, adc_cmpr_latch_ctl_o,
               spi_interrupt_ctl_o}), $sampled({exp_pins.f.adc_refmux, exp_pins.f.adc_rstmux,
               exp_pins.f.adc_sigmux, exp_pins.f.adc_cmpr_latch, exp_pins.f.spi_interrupt}));
    end

  a_seq_azmux: assert property (@(posedge CLK) disable iff (!rst_n_i)
    seq_chk |-> azmux_o == exp_seq[exp_idx].azmux)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: azmux_o got %h expected %h",
               $time, $sampled(azmux_o), $sampled(exp_seq[exp_idx].azmux));
    end
  a_seq_pc_sw: assert property (@(posedge CLK) disable iff (!rst_n_i)
    seq_chk |-> pc_sw_o == exp_seq[exp_idx].pc_sw)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: pc_sw_o got %h expected %h",
               $time, $sampled(pc_sw_o), $sampled(exp_seq[exp_idx].pc_sw));
    end
  a_precharge: assert property (@(posedge CLK) disable iff (!rst_n_i)
    seq_chk && $rose(monitor_o[0]) |-> low_cnt >= prech_cycles)
    else
    begin
      errors++;
      $display("adc reset released at %0t ns after only %0d low cycles, precharge %0d",
               $time, $sampled(low_cnt), prech_cycles);
    end

  a_read: assert property (@(posedge CLK) disable iff (!rst_n_i) rd_chk |-> rd_got == rd_exp)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h",
               $time, rd_name, $sampled(rd_got), $sampled(rd_exp));
    end

  //////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};        // one step per bit
    end
  endtask

  function automatic logic [31:0] status_word(input logic [2:0] seq_n, input logic [2:0] idx,
                                              input logic first);
    dmm_reg_pkg::status_fields_t s;
    s            = '0;
    s.magic      = 8'hAA;
    s.hw_flags   = hw_flags_i;
    s.sample_idx = idx;
    s.first      = first;
    s.seq_n      = seq_n;
    return s;
  endfunction

  task automatic finish_run();
    $display("run done: frames %0d errors %0d timeouts %0d", frames, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  // one 40 bit mode 0 frame, sdo sampled at each rising sck
  task automatic spi_frame(input logic wr, input logic [6:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {wr, addr, wdata};
    rdata = '0;
    @(negedge CLK);
    spi_cs_vec_i = `DMM_CS_FPGA0;
    SCK          = 1'b0;
    repeat (HALF_SCK) @(negedge CLK);
    for (int i = 39; i >= 0; i--)
    begin
      SDI = frame[i];
      repeat (HALF_SCK) @(negedge CLK);
      SCK = 1'b1;
      if (i < 32)
        rdata = {rdata[30:0], SDO};
      repeat (HALF_SCK) @(negedge CLK);
      SCK = 1'b0;
    end
    repeat (HALF_SCK) @(negedge CLK);
    spi_cs_vec_i = `DMM_CS_DEASSERT;
    SDI          = 1'b0;
    repeat (HALF_SCK) @(negedge CLK);   // commit lands within 8 cycles
    frames++;
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] dummy;
    spi_frame(1'b1, addr, data, dummy);
  endtask

  task automatic expect_read(input string name, input logic [6:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    spi_frame(1'b0, addr, 32'h0, got);
    rd_name = name;
    rd_got  = got;
    rd_exp  = exp;
    rd_chk  = 1'b1;
    @(negedge CLK);
    rd_chk  = 1'b0;
  endtask

  task automatic wait_release(input int limit);
    int n;
    n = 0;
    while (monitor_o[0] !== 1'b1 && n < limit)
    begin
      @(negedge CLK);
      n++;
    end
    if (monitor_o[0] !== 1'b1)
    begin
      $display("timeout at %0t ns: adc reset never released in sequence mode", $time);
      timeouts++;
      finish_run();
    end
  endtask

  task automatic wait_samples(input int target, input int limit);
    int n;
    n = 0;
    while (sample_cnt < target && n < limit)
    begin
      @(negedge CLK);
      n++;
    end
    if (sample_cnt < target)
    begin
      $display("timeout at %0t ns: only %0d of %0d samples seen", $time, sample_cnt, target);
      timeouts++;
      finish_run();
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus

  initial
  begin
    logic [31:0] w, last_direct;
    int          modes [6];
    int          base;
    modes = '{1, 2, 3, 4, 5, 7};
    rst_n_i      = 1'b0;
    SCK          = 1'b0;
    SDI          = 1'b0;
    spi_cs_vec_i = `DMM_CS_DEASSERT;
    spi_glb_miso = 1'b0;
    adc_cmpr_i   = 1'b0;
    sa_trig_i    = 1'b0;
    chk_pins     = 1'b0;
    chk_oe       = 1'b0;
    seq_chk      = 1'b0;
    rd_chk       = 1'b0;
    exp_pins     = '0;
    exp_oe       = 1'b0;
    seq_n_cfg    = 3'd3;
    prech_cycles = 0;
    low_cnt      = 0;
    sample_cnt   = 0;
    rand_bits(4, w);
    hw_flags_i   = w[3:0];
    repeat (16) @(negedge CLK);
    rst_n_i = 1'b1;

    // reset state and status magic
    chk_pins = 1'b1;                  // all pins zero
    chk_oe   = 1'b1;
    expect_read("status after reset", `DMM_REG_STATUS, status_word(3'd0, 3'd0, 1'b0));

    // read back of random words, direct pins follow
    rand_bits(32, w);
    chk_pins = 1'b0;
    write_reg(`DMM_REG_DIRECT, w);
    exp_pins.word = w;
    chk_pins      = 1'b1;
    expect_read("direct readback", `DMM_REG_DIRECT, w);
    rand_bits(32, w);
    write_reg(`DMM_REG_SA_SEQ0, w);
    expect_read("sa_seq0 readback", `DMM_REG_SA_SEQ0, w);
    rand_bits(32, w);
    write_reg(`DMM_REG_ADC_APERTURE, w);
    expect_read("aperture readback", `DMM_REG_ADC_APERTURE, w);
    rand_bits(32, w);
    write_reg(`DMM_REG_STATUS, w);    // read only
    expect_read("status after write", `DMM_REG_STATUS, status_word(3'd0, 3'd0, 1'b0));

    // cs decode sweep with random sck and sdi
    chk_oe = 1'b0;
    rand_bits(32, w);
    write_reg(`DMM_REG_4094_OE, w);
    exp_oe = w[0];
    chk_oe = 1'b1;
    for (int cs = 0; cs < 8; cs++)
    begin
      for (int k = 0; k < 4; k++)
      begin
        rand_bits(2, w);
        spi_cs_vec_i = 3'(cs);
        {SCK, SDI}   = w[1:0];
        repeat (2) @(negedge CLK);
      end
    end
    spi_cs_vec_i = `DMM_CS_DEASSERT;  // short fpga frame gets dropped
    SCK          = 1'b0;
    SDI          = 1'b0;
    repeat (HALF_SCK) @(negedge CLK);

    // direct decode of a few more words
    for (int k = 0; k < 3; k++)
    begin
      rand_bits(32, w);
      chk_pins = 1'b0;
      write_reg(`DMM_REG_DIRECT, w);
      exp_pins.word = w;
      chk_pins      = 1'b1;
      repeat (4) @(negedge CLK);
    end
    last_direct = w;

    // unused modes drive nothing
    foreach (modes[m])
    begin
      chk_pins = 1'b0;
      write_reg(`DMM_REG_CR, 32'(modes[m]));
      exp_pins = '0;
      chk_pins = 1'b1;
      repeat (4) @(negedge CLK);
    end
    chk_pins = 1'b0;
    write_reg(`DMM_REG_CR, 32'(`DMM_MODE_DIRECT));
    exp_pins.word = last_direct;
    chk_pins      = 1'b1;
    repeat (4) @(negedge CLK);

    //////////////////////////////////////////////////
    // mode 6 sequence over three entries

    chk_pins = 1'b0;
    rand_bits(3, w);
    prech_cycles = 4 + w;
    write_reg(`DMM_REG_SA_PRECHARGE, 32'(prech_cycles));
    rand_bits(3, w);
    write_reg(`DMM_REG_ADC_APERTURE, 32'd4 + w);
    write_reg(`DMM_REG_SA_SEQ_N, 32'(seq_n_cfg));
    for (int i = 0; i < 3; i++)
    begin
      rand_bits(32, w);
      exp_seq[i] = w[5:0];            // pc_sw over azmux
      write_reg(7'(`DMM_REG_SA_SEQ0 + i), w);
    end
    write_reg(`DMM_REG_CR, 32'(`DMM_MODE_SEQ_MOCK));

    sa_trig_i = 1'b1;
    wait_release(200);
    seq_chk = 1'b1;
    base    = sample_cnt;
    wait_samples(base + N_SAMPLES, 2000);
    seq_chk   = 1'b0;
    sa_trig_i = 1'b0;                 // next sample is far off
    expect_read("status after stop", `DMM_REG_STATUS,
                status_word(seq_n_cfg, 3'((N_SAMPLES - 1) % seq_n_cfg), 1'b0));

    // retrigger, one sample only
    sa_trig_i = 1'b1;
    wait_release(200);
    seq_chk = 1'b1;
    base    = sample_cnt;
    wait_samples(base + 1, 500);
    seq_chk   = 1'b0;
    sa_trig_i = 1'b0;
    expect_read("status after retrigger", `DMM_REG_STATUS, status_word(seq_n_cfg, 3'd0, 1'b1));

    repeat (4) @(negedge CLK);
    finish_run();
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
dmm_reg_pkg.sv
dmm_acq_pkg.sv
spi_register_set.sv
adc_mock.sv
sequence_acquisition.sv
output_mode_mux.sv
dmm_top.sv
tb_dmm_top.sv
